// File: rtl/axi_mem_pkg.sv
package axi_mem_pkg;

  // Bus widths shared by both slave ports
  localparam int AXI_ADDR_BITS = 32;   // Byte address
  localparam int AXI_DATA_BITS = 32;   // One memory word per beat

  // Byte lanes per data word, also the write strobe width
  localparam int AXI_STRB_BITS = AXI_DATA_BITS / 8;

  // Response codes in use; EXOKAY and DECERR are never returned
  typedef enum logic [1:0] {
    AXI_RESP_OKAY   = 2'b00,
    AXI_RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

// File: rtl/dual_port_memory.sv
`timescale 1ns/1ps

module dual_port_memory
  import axi_mem_pkg::*;
#(
  parameter int unsigned MEM_WORDS = 1024,
  localparam int ADDR_W = $clog2(MEM_WORDS)
) (
  input  logic                     ACLK,

  // Port A, read only
  input  logic [ADDR_W-1:0]        a_addr,        // Word index
  input  logic                     a_ren,
  output logic [AXI_DATA_BITS-1:0] a_rdata,

  // Port B, read or byte-lane write
  input  logic [ADDR_W-1:0]        b_addr,        // Word index
  input  logic                     b_ren,
  input  logic                     b_wen,
  input  logic [AXI_STRB_BITS-1:0] b_wstrb,
  input  logic [AXI_DATA_BITS-1:0] b_wdata,
  output logic [AXI_DATA_BITS-1:0] b_rdata
);

  logic [AXI_DATA_BITS-1:0] mem [MEM_WORDS];

  // Port A read, output held until the next strobe
  always_ff @(posedge ACLK) begin
    if (a_ren) begin
      a_rdata <= mem[a_addr];
    end
  end

  // Port B read
  always_ff @(posedge ACLK) begin
    if (b_ren) begin
      b_rdata <= mem[b_addr];
    end
  end

  // Port B write, only strobed lanes change
  always_ff @(posedge ACLK) begin
    if (b_wen) begin
      for (int lane = 0; lane < AXI_STRB_BITS; lane++) begin
        if (b_wstrb[lane]) begin
          mem[b_addr][lane*8 +: 8] <= b_wdata[lane*8 +: 8];
        end
      end
    end
  end

endmodule

// File: rtl/imem_axi_port.sv
`timescale 1ns/1ps

module imem_axi_port
  import axi_mem_pkg::*;
#(
  parameter int unsigned MEM_WORDS = 1024,
  localparam int ADDR_W = $clog2(MEM_WORDS)
) (
  input  logic                     ACLK,
  input  logic                     ARESETn,
  input  logic [AXI_ADDR_BITS-1:0] araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [AXI_DATA_BITS-1:0] rdata,
  output axi_resp_e                rresp,
  output logic                     rvalid,
  input  logic                     rready,
  output logic                     awready,
  output logic                     wready,
  output logic                     bvalid,
  output axi_resp_e                bresp,
  output logic [ADDR_W-1:0]        a_addr,
  output logic                     a_ren,
  input  logic [AXI_DATA_BITS-1:0] a_rdata
);

  logic                     ar_hs;
  logic                     ar_err;
  logic                     r_hs;
  logic                     s1_vld;         // Memory strobe issued
  logic                     s1_err;
  logic                     s2_vld;         // Memory data ready
  logic                     s2_err;
  logic [1:0]               outstanding;    // Accepted, not yet handed over
  logic [AXI_DATA_BITS-1:0] fifo_data [2];
  axi_resp_e                fifo_resp [2];
  logic                     wr_ptr;
  logic                     rd_ptr;
  logic [1:0]               fifo_cnt;

  // Fetch port has no write path
  assign awready = 1'b0;
  assign wready  = 1'b0;
  assign bvalid  = 1'b0;
  assign bresp   = AXI_RESP_OKAY;

  assign arready = outstanding < 2'd2;  // At most two in flight
  assign ar_hs   = arvalid && arready;
  assign ar_err  = araddr[AXI_ADDR_BITS-1:2] >= MEM_WORDS;
  assign rvalid  = fifo_cnt != 2'd0;
  assign rdata   = fifo_data[rd_ptr];
  assign rresp   = fifo_resp[rd_ptr];
  assign r_hs    = rvalid && rready;

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      a_ren       <= 1'b0;
      s1_vld      <= 1'b0;
      s2_vld      <= 1'b0;
      outstanding <= 2'd0;
      wr_ptr      <= 1'b0;
      rd_ptr      <= 1'b0;
      fifo_cnt    <= 2'd0;
    end else begin
      a_ren       <= ar_hs && !ar_err;  // No strobe for out-of-range
      s1_vld      <= ar_hs;
      s2_vld      <= s1_vld;
      outstanding <= outstanding + {1'b0, ar_hs} - {1'b0, r_hs};
      fifo_cnt    <= fifo_cnt + {1'b0, s2_vld} - {1'b0, r_hs};
      if (s2_vld) begin
        wr_ptr <= !wr_ptr;
      end
      if (r_hs) begin
        rd_ptr <= !rd_ptr;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (ar_hs) begin
      a_addr <= araddr[ADDR_W+1:2];
    end
    s1_err <= ar_err;
    s2_err <= s1_err;
    // Capacity is guaranteed by the outstanding count
    if (s2_vld) begin
      fifo_data[wr_ptr] <= s2_err ? '0 : a_rdata;
      fifo_resp[wr_ptr] <= s2_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    end
  end

endmodule

// File: rtl/dmem_axi_port.sv
`timescale 1ns/1ps

module dmem_axi_port
  import axi_mem_pkg::*;
#(
  parameter int unsigned MEM_WORDS = 1024,
  localparam int ADDR_W = $clog2(MEM_WORDS)
) (
  input  logic                     ACLK,
  input  logic                     ARESETn,
  input  logic [AXI_ADDR_BITS-1:0] araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [AXI_DATA_BITS-1:0] rdata,
  output axi_resp_e                rresp,
  output logic                     rvalid,
  input  logic                     rready,
  input  logic [AXI_ADDR_BITS-1:0] awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [AXI_DATA_BITS-1:0] wdata,
  input  logic [AXI_STRB_BITS-1:0] wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic                     bvalid,
  output axi_resp_e                bresp,
  input  logic                     bready,
  output logic [ADDR_W-1:0]        b_addr,
  output logic                     b_ren,
  output logic                     b_wen,
  output logic [AXI_STRB_BITS-1:0] b_wstrb,
  output logic [AXI_DATA_BITS-1:0] b_wdata,
  input  logic [AXI_DATA_BITS-1:0] b_rdata
);

  logic                     ar_hs;
  logic                     ar_err;
  logic                     r_hs;
  logic                     wr_hs;          // AW and W taken together
  logic                     aw_err;
  logic                     wr_pend;        // Write strobed this cycle
  logic                     wr_err;
  logic                     s1_vld;
  logic                     s1_err;
  logic                     s2_vld;
  logic                     s2_err;
  logic [1:0]               outstanding;
  logic [AXI_DATA_BITS-1:0] fifo_data [2];
  axi_resp_e                fifo_resp [2];
  logic                     wr_ptr;
  logic                     rd_ptr;
  logic [1:0]               fifo_cnt;

  // Read side, same pipeline as the fetch port
  assign arready = outstanding < 2'd2;
  assign ar_hs   = arvalid && arready;
  assign ar_err  = araddr[AXI_ADDR_BITS-1:2] >= MEM_WORDS;
  assign rvalid  = fifo_cnt != 2'd0;
  assign rdata   = fifo_data[rd_ptr];
  assign rresp   = fifo_resp[rd_ptr];
  assign r_hs    = rvalid && rready;

  // A pending read wins, and B must have room for one more response
  assign wr_hs   = awvalid && wvalid && !arvalid && !wr_pend && (!bvalid || bready);
  assign awready = wr_hs;
  assign wready  = wr_hs;
  assign aw_err  = awaddr[AXI_ADDR_BITS-1:2] >= MEM_WORDS;

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      b_ren       <= 1'b0;
      b_wen       <= 1'b0;
      wr_pend     <= 1'b0;
      s1_vld      <= 1'b0;
      s2_vld      <= 1'b0;
      outstanding <= 2'd0;
      wr_ptr      <= 1'b0;
      rd_ptr      <= 1'b0;
      fifo_cnt    <= 2'd0;
      bvalid      <= 1'b0;
      bresp       <= AXI_RESP_OKAY;
    end else begin
      b_ren       <= ar_hs && !ar_err;
      b_wen       <= wr_hs && !aw_err;  // Out-of-range write is dropped
      wr_pend     <= wr_hs;
      s1_vld      <= ar_hs;
      s2_vld      <= s1_vld;
      outstanding <= outstanding + {1'b0, ar_hs} - {1'b0, r_hs};
      fifo_cnt    <= fifo_cnt + {1'b0, s2_vld} - {1'b0, r_hs};
      if (s2_vld) begin
        wr_ptr <= !wr_ptr;
      end
      if (r_hs) begin
        rd_ptr <= !rd_ptr;
      end
      // B answers one cycle after the write handshake
      if (wr_pend) begin
        bvalid <= 1'b1;
        bresp  <= wr_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (ar_hs) begin
      b_addr <= araddr[ADDR_W+1:2];
    end else if (wr_hs) begin
      b_addr <= awaddr[ADDR_W+1:2];
    end
    if (wr_hs) begin
      b_wdata <= wdata;
      b_wstrb <= wstrb;
      wr_err  <= aw_err;
    end
    s1_err <= ar_err;
    s2_err <= s1_err;
    if (s2_vld) begin
      fifo_data[wr_ptr] <= s2_err ? '0 : b_rdata;
      fifo_resp[wr_ptr] <= s2_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    end
  end

endmodule

// File: rtl/axi_memory_wrapper.sv
`timescale 1ns/1ps

module axi_memory_wrapper
  import axi_mem_pkg::*;
#(
  parameter int unsigned MEM_WORDS = 1024,
  localparam int ADDR_W = $clog2(MEM_WORDS)
) (
  input  logic                     ACLK,
  input  logic                     ARESETn,

  // Slave 0, instruction fetch
  input  logic [AXI_ADDR_BITS-1:0] araddr_s0,
  input  logic                     arvalid_s0,
  output logic                     arready_s0,
  output logic [AXI_DATA_BITS-1:0] rdata_s0,
  output axi_resp_e                rresp_s0,
  output logic                     rvalid_s0,
  input  logic                     rready_s0,
  input  logic [AXI_ADDR_BITS-1:0] awaddr_s0,   // Write side not served
  input  logic                     awvalid_s0,
  output logic                     awready_s0,
  input  logic [AXI_DATA_BITS-1:0] wdata_s0,
  input  logic [AXI_STRB_BITS-1:0] wstrb_s0,
  input  logic                     wvalid_s0,
  output logic                     wready_s0,
  output axi_resp_e                bresp_s0,
  output logic                     bvalid_s0,
  input  logic                     bready_s0,

  // Slave 1, data access
  input  logic [AXI_ADDR_BITS-1:0] araddr_s1,
  input  logic                     arvalid_s1,
  output logic                     arready_s1,
  output logic [AXI_DATA_BITS-1:0] rdata_s1,
  output axi_resp_e                rresp_s1,
  output logic                     rvalid_s1,
  input  logic                     rready_s1,
  input  logic [AXI_ADDR_BITS-1:0] awaddr_s1,
  input  logic                     awvalid_s1,
  output logic                     awready_s1,
  input  logic [AXI_DATA_BITS-1:0] wdata_s1,
  input  logic [AXI_STRB_BITS-1:0] wstrb_s1,
  input  logic                     wvalid_s1,
  output logic                     wready_s1,
  output axi_resp_e                bresp_s1,
  output logic                     bvalid_s1,
  input  logic                     bready_s1
);

  logic [ADDR_W-1:0]        a_addr;
  logic                     a_ren;
  logic [AXI_DATA_BITS-1:0] a_rdata;
  logic [ADDR_W-1:0]        b_addr;
  logic                     b_ren;
  logic                     b_wen;
  logic [AXI_STRB_BITS-1:0] b_wstrb;
  logic [AXI_DATA_BITS-1:0] b_wdata;
  logic [AXI_DATA_BITS-1:0] b_rdata;

  dual_port_memory #(
    .MEM_WORDS(MEM_WORDS)
  ) u_mem (
    .ACLK,
    .a_addr,
    .a_ren,
    .a_rdata,
    .b_addr,
    .b_ren,
    .b_wen,
    .b_wstrb,
    .b_wdata,
    .b_rdata
  );

  imem_axi_port #(
    .MEM_WORDS(MEM_WORDS)
  ) u_imem_port (
    .ACLK,
    .ARESETn,
    .araddr  (araddr_s0),
    .arvalid (arvalid_s0),
    .arready (arready_s0),
    .rdata   (rdata_s0),
    .rresp   (rresp_s0),
    .rvalid  (rvalid_s0),
    .rready  (rready_s0),
    .awready (awready_s0),
    .wready  (wready_s0),
    .bvalid  (bvalid_s0),
    .bresp   (bresp_s0),
    .a_addr,
    .a_ren,
    .a_rdata
  );

  dmem_axi_port #(
    .MEM_WORDS(MEM_WORDS)
  ) u_dmem_port (
    .ACLK,
    .ARESETn,
    .araddr  (araddr_s1),
    .arvalid (arvalid_s1),
    .arready (arready_s1),
    .rdata   (rdata_s1),
    .rresp   (rresp_s1),
    .rvalid  (rvalid_s1),
    .rready  (rready_s1),
    .awaddr  (awaddr_s1),
    .awvalid (awvalid_s1),
    .awready (awready_s1),
    .wdata   (wdata_s1),
    .wstrb   (wstrb_s1),
    .wvalid  (wvalid_s1),
    .wready  (wready_s1),
    .bvalid  (bvalid_s1),
    .bresp   (bresp_s1),
    .bready  (bready_s1),
    .b_addr,
    .b_ren,
    .b_wen,
    .b_wstrb,
    .b_wdata,
    .b_rdata
  );

endmodule

// File: bench/axi_memory_wrapper_asserts.sv
`timescale 1ns/1ps

module axi_memory_wrapper_asserts
  import axi_mem_pkg::*;
(
  input logic                     ACLK,
  input logic                     ARESETn,
  input logic [AXI_DATA_BITS-1:0] rdata_s0,
  input logic [AXI_DATA_BITS-1:0] rdata_s1,
  input axi_resp_e                rresp_s0,
  input axi_resp_e                rresp_s1,
  input axi_resp_e                bresp_s1,
  input logic                     rvalid_s0,
  input logic                     rready_s0,
  input logic                     rvalid_s1,
  input logic                     rready_s1,
  input logic                     bvalid_s0,
  input logic                     bvalid_s1,
  input logic                     bready_s1,
  input logic                     arvalid_s1,
  input logic                     arready_s1,
  input logic                     awready_s1
);

  r0_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rvalid_s0 && !rready_s0 |=> rvalid_s0 && $stable(rdata_s0) && $stable(rresp_s0))
    else $error("port 0 R payload changed while waiting for RREADY");

  r1_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rvalid_s1 && !rready_s1 |=> rvalid_s1 && $stable(rdata_s1) && $stable(rresp_s1))
    else $error("port 1 R payload changed while waiting for RREADY");

  b1_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    bvalid_s1 && !bready_s1 |=> bvalid_s1 && $stable(bresp_s1))
    else $error("port 1 B response changed while waiting for BREADY");

  // Fetch port has no write channel
  no_b_s0: assert property (@(posedge ACLK) disable iff (!ARESETn) !bvalid_s0)
    else $error("port 0 raised BVALID");

  read_wins: assert property (@(posedge ACLK) disable iff (!ARESETn)
    !(awready_s1 && arvalid_s1 && arready_s1))
    else $error("port 1 took a write in the same cycle as a read");

endmodule

bind axi_memory_wrapper axi_memory_wrapper_asserts u_asserts (.*);

// File: include/tb_axi_tasks.svh
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

int pass_count;
int fail_count;

task automatic check_data(input string what, input logic [AXI_DATA_BITS-1:0] got,
                          input logic [AXI_DATA_BITS-1:0] exp);
  if (got === exp) begin
    pass_count++;
  end else begin
    fail_count++;
    $display("ERROR %s: data %h, expected %h", what, got, exp);
  end
endtask

task automatic check_resp(input string what, input axi_resp_e got, input axi_resp_e exp);
  if (got === exp) begin
    pass_count++;
  end else begin
    fail_count++;
    $display("ERROR %s: resp %s, expected %s", what, got.name(), exp.name());
  end
endtask

// Single read on the fetch port, inputs change 1 ns after the edge
task automatic axi_read_s0(input logic [AXI_ADDR_BITS-1:0] addr,
                           output logic [AXI_DATA_BITS-1:0] data, output axi_resp_e resp);
  araddr_s0  = addr;
  arvalid_s0 = 1'b1;
  do @(posedge ACLK); while (!arready_s0);
  #1;
  arvalid_s0 = 1'b0;
  rready_s0  = 1'b1;
  do @(posedge ACLK); while (!rvalid_s0);
  data = rdata_s0;
  resp = rresp_s0;
  #1;
  rready_s0 = 1'b0;
endtask

task automatic axi_read_s1(input logic [AXI_ADDR_BITS-1:0] addr,
                           output logic [AXI_DATA_BITS-1:0] data, output axi_resp_e resp);
  araddr_s1  = addr;
  arvalid_s1 = 1'b1;
  do @(posedge ACLK); while (!arready_s1);
  #1;
  arvalid_s1 = 1'b0;
  rready_s1  = 1'b1;
  do @(posedge ACLK); while (!rvalid_s1);
  data = rdata_s1;
  resp = rresp_s1;
  #1;
  rready_s1 = 1'b0;
endtask

// AW and W are offered together, then B is collected
task automatic axi_write_s1(input logic [AXI_ADDR_BITS-1:0] addr,
                            input logic [AXI_DATA_BITS-1:0] data,
                            input logic [AXI_STRB_BITS-1:0] strb, output axi_resp_e resp);
  awaddr_s1  = addr;
  awvalid_s1 = 1'b1;
  wdata_s1   = data;
  wstrb_s1   = strb;
  wvalid_s1  = 1'b1;
  do @(posedge ACLK); while (!(awready_s1 && wready_s1));
  #1;
  awvalid_s1 = 1'b0;
  wvalid_s1  = 1'b0;
  bready_s1  = 1'b1;
  do @(posedge ACLK); while (!bvalid_s1);
  resp = bresp_s1;
  #1;
  bready_s1 = 1'b0;
endtask

`endif

// File: bench/tb_axi_memory_wrapper.sv
`timescale 1ns/1ps

module tb_axi_memory_wrapper
  import axi_mem_pkg::*;
();

  localparam int MEM_WORDS  = 256;
  localparam int CLK_PERIOD = 100;
  localparam int OP_CYCLES  = 6;     // Bound for one single-beat transfer
  localparam int READBACKS  = 32;
  localparam int PARTIALS   = 16;
  localparam int TEST_CYCLES =
    52 + OP_CYCLES * (2 * MEM_WORDS + 2 * READBACKS + 2 * PARTIALS + 6);
  localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;

  logic                     ACLK, ARESETn;
  logic [AXI_ADDR_BITS-1:0] araddr_s0, awaddr_s0, araddr_s1, awaddr_s1;
  logic [AXI_DATA_BITS-1:0] rdata_s0, wdata_s0, rdata_s1, wdata_s1;
  logic [AXI_STRB_BITS-1:0] wstrb_s0, wstrb_s1;
  logic                     arvalid_s0, arready_s0, rvalid_s0, rready_s0;
  logic                     awvalid_s0, awready_s0, wvalid_s0, wready_s0, bvalid_s0, bready_s0;
  logic                     arvalid_s1, arready_s1, rvalid_s1, rready_s1;
  logic                     awvalid_s1, awready_s1, wvalid_s1, wready_s1, bvalid_s1, bready_s1;
  axi_resp_e                rresp_s0, bresp_s0, rresp_s1, bresp_s1;
  logic [AXI_DATA_BITS-1:0] shadow [MEM_WORDS];   // Expected memory contents

  `include "tb_axi_tasks.svh"

  axi_memory_wrapper #(.MEM_WORDS(MEM_WORDS)) u_dut (.*);

  initial begin
    ACLK = 1'b0;
    forever #(CLK_PERIOD / 2) ACLK = ~ACLK;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got === exp) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("ERROR %s: flag %b, expected %b", what, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int fails_before);
    if (fail_count == fails_before) begin
      $display("%s: all checks passed", name);
    end else begin
      $display("%s: %0d check(s) failed", name, fail_count - fails_before);
    end
  endtask

  // Old word with the strobed byte lanes replaced
  function automatic logic [AXI_DATA_BITS-1:0] merge_lanes(input logic [AXI_DATA_BITS-1:0] old_w,
      input logic [AXI_DATA_BITS-1:0] new_w, input logic [AXI_STRB_BITS-1:0] strb);
    logic [AXI_DATA_BITS-1:0] result;
    result = old_w;
    for (int lane = 0; lane < AXI_STRB_BITS; lane++) begin
      if (strb[lane]) begin
        result[lane*8 +: 8] = new_w[lane*8 +: 8];
      end
    end
    return result;
  endfunction

  task automatic test_reset_state();
    int fails_before;
    fails_before = fail_count;
    check_flag("reset_state rvalid_s0", rvalid_s0, 1'b0);
    check_flag("reset_state rvalid_s1", rvalid_s1, 1'b0);
    check_flag("reset_state bvalid_s0", bvalid_s0, 1'b0);
    check_flag("reset_state bvalid_s1", bvalid_s1, 1'b0);
    check_flag("reset_state awready_s0", awready_s0, 1'b0);
    check_flag("reset_state wready_s0", wready_s0, 1'b0);
    check_flag("reset_state awready_s1", awready_s1, 1'b0);
    check_flag("reset_state wready_s1", wready_s1, 1'b0);
    check_flag("reset_state arready_s0", arready_s0, 1'b1);
    check_flag("reset_state arready_s1", arready_s1, 1'b1);
    check_resp("reset_state bresp_s0", bresp_s0, AXI_RESP_OKAY);
    finish_test("reset_state", fails_before);
  endtask

  task automatic test_fill_and_readback();
    int fails_before;
    int idx;
    logic [AXI_DATA_BITS-1:0] data;
    axi_resp_e resp;
    fails_before = fail_count;
    for (int i = 0; i < MEM_WORDS; i++) begin
      data = $urandom();
      axi_write_s1(i * 4, data, '1, resp);
      check_resp($sformatf("fill_and_readback write word %0d", i), resp, AXI_RESP_OKAY);
      shadow[i] = data;
    end
    for (int i = 0; i < READBACKS; i++) begin
      idx = $urandom_range(MEM_WORDS - 1);
      axi_read_s1(idx * 4, data, resp);
      check_data($sformatf("fill_and_readback s1 word %0d", idx), data, shadow[idx]);
      check_resp($sformatf("fill_and_readback s1 word %0d", idx), resp, AXI_RESP_OKAY);
      axi_read_s0(idx * 4, data, resp);
      check_data($sformatf("fill_and_readback s0 word %0d", idx), data, shadow[idx]);
      check_resp($sformatf("fill_and_readback s0 word %0d", idx), resp, AXI_RESP_OKAY);
    end
    finish_test("fill_and_readback", fails_before);
  endtask

  task automatic test_partial_strobe();
    int fails_before;
    int idx;
    logic [AXI_DATA_BITS-1:0] data;
    logic [AXI_STRB_BITS-1:0] strb;
    axi_resp_e resp;
    fails_before = fail_count;
    for (int i = 0; i < PARTIALS; i++) begin
      idx  = $urandom_range(MEM_WORDS - 1);
      data = $urandom();
      strb = $urandom();
      axi_write_s1(idx * 4, data, strb, resp);
      check_resp($sformatf("partial_strobe write word %0d", idx), resp, AXI_RESP_OKAY);
      shadow[idx] = merge_lanes(shadow[idx], data, strb);
      axi_read_s1(idx * 4, data, resp);
      check_data($sformatf("partial_strobe word %0d strb %b", idx, strb), data, shadow[idx]);
    end
    finish_test("partial_strobe", fails_before);
  endtask

  task automatic test_out_of_range();
    int fails_before;
    logic [AXI_DATA_BITS-1:0] data;
    axi_resp_e resp;
    fails_before = fail_count;
    axi_read_s1(MEM_WORDS * 4, data, resp);
    check_resp("out_of_range s1 read", resp, AXI_RESP_SLVERR);
    check_data("out_of_range s1 read", data, '0);
    axi_read_s0((MEM_WORDS + 17) * 4, data, resp);
    check_resp("out_of_range s0 read", resp, AXI_RESP_SLVERR);
    axi_write_s1(MEM_WORDS * 4, $urandom(), '1, resp);   // Aliases word 0 if not dropped
    check_resp("out_of_range write low", resp, AXI_RESP_SLVERR);
    axi_write_s1(32'hFFFF_FFFC, $urandom(), '1, resp);
    check_resp("out_of_range write high", resp, AXI_RESP_SLVERR);
    for (int i = 0; i < MEM_WORDS; i++) begin
      axi_read_s0(i * 4, data, resp);
      check_data($sformatf("out_of_range keep word %0d", i), data, shadow[i]);
    end
    finish_test("out_of_range", fails_before);
  endtask

  task automatic test_s0_in_order();
    int fails_before;
    int idx0;
    int idx1;
    logic [AXI_DATA_BITS-1:0] data0, data1;
    fails_before = fail_count;
    idx0 = $urandom_range(MEM_WORDS - 1);
    idx1 = (idx0 + 1 + $urandom_range(MEM_WORDS - 2)) % MEM_WORDS;
    araddr_s0  = idx0 * 4;
    arvalid_s0 = 1'b1;
    do @(posedge ACLK); while (!arready_s0);
    #1;
    araddr_s0 = idx1 * 4;
    do @(posedge ACLK); while (!arready_s0);
    #1;
    arvalid_s0 = 1'b0;
    check_flag("s0_in_order arready with two in flight", arready_s0, 1'b0);
    while (!rvalid_s0) @(posedge ACLK);
    #1;
    rready_s0 = 1'b1;
    do @(posedge ACLK); while (!rvalid_s0);
    data0 = rdata_s0;
    do @(posedge ACLK); while (!rvalid_s0);
    data1 = rdata_s0;
    #1;
    rready_s0 = 1'b0;
    check_data("s0_in_order first beat", data0, shadow[idx0]);
    check_data("s0_in_order second beat", data1, shadow[idx1]);
    finish_test("s0_in_order", fails_before);
  endtask

  task automatic test_s1_read_wins();
    int fails_before;
    int idx;
    int cycle;
    int ar_cycle;
    int wr_cycle;
    bit r_seen, b_seen;
    logic [AXI_DATA_BITS-1:0] new_w, data;
    axi_resp_e resp, b_resp;
    fails_before = fail_count;
    idx = $urandom_range(MEM_WORDS - 1);
    new_w = $urandom();
    {r_seen, b_seen, cycle, ar_cycle, wr_cycle} = '0;
    araddr_s1 = idx * 4;
    awaddr_s1 = idx * 4;
    wdata_s1  = new_w;
    wstrb_s1  = '1;
    {arvalid_s1, awvalid_s1, wvalid_s1, rready_s1, bready_s1} = '1;
    while (!(r_seen && b_seen)) begin
      @(posedge ACLK);
      cycle++;
      if (arvalid_s1 && arready_s1) ar_cycle = cycle;
      if (awvalid_s1 && awready_s1 && wvalid_s1 && wready_s1) wr_cycle = cycle;
      if (rvalid_s1 && !r_seen) begin
        r_seen = 1'b1;
        data   = rdata_s1;
        resp   = rresp_s1;
      end
      if (bvalid_s1 && !b_seen) begin
        b_seen = 1'b1;
        b_resp = bresp_s1;
      end
      #1;
      if (ar_cycle != 0) arvalid_s1 = 1'b0;
      if (wr_cycle != 0) {awvalid_s1, wvalid_s1} = '0;
    end
    {rready_s1, bready_s1} = '0;
    check_flag("s1_read_wins read accepted first", ar_cycle < wr_cycle, 1'b1);
    check_data("s1_read_wins old word", data, shadow[idx]);
    check_resp("s1_read_wins read resp", resp, AXI_RESP_OKAY);
    check_resp("s1_read_wins write resp", b_resp, AXI_RESP_OKAY);
    shadow[idx] = new_w;
    axi_read_s1(idx * 4, data, resp);
    check_data("s1_read_wins new word", data, shadow[idx]);
    finish_test("s1_read_wins", fails_before);
  endtask

  initial begin
    void'($urandom(39859));
    ARESETn = 1'b0;
    {araddr_s0, awaddr_s0, wdata_s0, wstrb_s0} = '0;
    {arvalid_s0, rready_s0, awvalid_s0, wvalid_s0, bready_s0} = '0;
    {araddr_s1, awaddr_s1, wdata_s1, wstrb_s1} = '0;
    {arvalid_s1, rready_s1, awvalid_s1, wvalid_s1, bready_s1} = '0;
    repeat (10) @(posedge ACLK);
    #1;
    ARESETn = 1'b1;
    test_reset_state();
    test_fill_and_readback();
    test_partial_strobe();
    test_out_of_range();
    test_s0_in_order();
    test_s1_read_wins();
    $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: axi_memory.f
+incdir+include
rtl/axi_mem_pkg.sv
rtl/dual_port_memory.sv
rtl/imem_axi_port.sv
rtl/dmem_axi_port.sv
rtl/axi_memory_wrapper.sv
bench/axi_memory_wrapper_asserts.sv
bench/tb_axi_memory_wrapper.sv

// File: Bender.yml
package:
  name: axi_memory

sources:
  - rtl/axi_mem_pkg.sv
  - rtl/dual_port_memory.sv
  - rtl/imem_axi_port.sv
  - rtl/dmem_axi_port.sv
  - rtl/axi_memory_wrapper.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/axi_memory_wrapper_asserts.sv
      - bench/tb_axi_memory_wrapper.sv
